// ==== logic/cache_macros.svh ====
//////////////////////////////
// Cache controller sizing macros
// Address, data, L1 geometry and main memory depth
//////////////////////////////
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// Byte address covers the whole 64 KiB main memory
`define ADDR_WIDTH 16

// One byte on the request and response ports
`define DATA_WIDTH 8

// L1 geometry
`define L1_INDEX_BITS 6   // 64 lines
`define OFFSET_BITS 2     // 4 bytes per line

`define MEM_WORDS 16384   // 32-bit words in main memory

`endif

// ==== logic/cache_addr_pkg.sv ====
//////////////////////////////
// Address fields and storage types
//////////////////////////////
package cache_addr_pkg;

`include "cache_macros.svh"

    // Derived geometry
    localparam int TAG_BITS   = `ADDR_WIDTH - `L1_INDEX_BITS - `OFFSET_BITS; // 8 tag bits
    localparam int L1_LINES   = 1 << `L1_INDEX_BITS;
    localparam int LINE_BYTES = 1 << `OFFSET_BITS;

    //////////////////////////////
    // Address pieces
    typedef logic [`ADDR_WIDTH-1:0]    addr_t;    // Full byte address
    typedef logic [TAG_BITS-1:0]       tag_t;     // Bits above index and offset
    typedef logic [`L1_INDEX_BITS-1:0] index_t;   // L1 line select
    typedef logic [`OFFSET_BITS-1:0]   offset_t;  // Byte within line

    //////////////////////////////
    // Storage
    typedef logic [`DATA_WIDTH-1:0] byte_t;
    // A line is also one memory word, indexed byte by byte
    typedef logic [LINE_BYTES-1:0][`DATA_WIDTH-1:0] line_t;
    typedef logic [`ADDR_WIDTH-`OFFSET_BITS-1:0] word_addr_t; // Byte address without offset

endpackage

// ==== logic/cache_ctrl_pkg.sv ====
//////////////////////////////
// Controller state and operation encodings
//////////////////////////////
package cache_ctrl_pkg;

    // Controller sequencing
    typedef enum logic [2:0] {
        ST_IDLE       = 3'd0,  // Waiting for enable
        ST_LOOKUP     = 3'd1,  // Tag compare on the captured request
        ST_WRITE_BACK = 3'd2,  // Dirty victim out to memory
        ST_REFILL     = 3'd3,  // Line in from memory
        ST_ACCESS     = 3'd4   // Byte read or merge after a miss
    } ctrl_state_e;

    // Request kind, straight from rw
    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } cache_op_e;

endpackage

// ==== logic/cache_ctrl_if.sv ====
//////////////////////////////
// Control strobes and status between FSM and line store
//////////////////////////////
`timescale 1ns/100ps

interface cache_ctrl_if;
    import cache_ctrl_pkg::*;

    // Strobes from the FSM
    logic accept;        // Capture request
    logic lookup;        // Lookup cycle
    logic write_back;    // Victim to memory
    logic refill;        // Line from memory
    logic access;        // Byte access after a miss

    // Status from the store
    logic      hit;
    logic      victim_dirty;
    cache_op_e op;       // Captured operation

    modport fsm   (output accept, lookup, write_back, refill, access,
                   input  hit, victim_dirty, op);
    modport store (input  accept, lookup, write_back, refill, access,
                   output hit, victim_dirty, op);

endinterface

// ==== logic/mem_bus_if.sv ====
//////////////////////////////
// Word port to main memory
//////////////////////////////
`timescale 1ns/100ps

interface mem_bus_if;
    import cache_addr_pkg::*;

    word_addr_t word_addr;  // Word select for both read and write
    line_t      wdata;      // Victim line
    logic       we;         // Write on the next edge
    line_t      rdata;      // Combinational read data

    modport ctrl (output word_addr, wdata, we, input rdata);
    modport mem  (input word_addr, wdata, we, output rdata);

endinterface

// ==== logic/cache_ctrl_fsm.sv ====
//////////////////////////////
// Cache controller FSM
// Sequences lookup, write-back, refill and access
//////////////////////////////
`timescale 1ns/100ps

module cache_ctrl_fsm (
    input  logic      clk,
    input  logic      reset_n,
    input  logic      enable,
    cache_ctrl_if.fsm ctrl,
    output logic      busy
);
    import cache_ctrl_pkg::*;

    ctrl_state_e state;
    ctrl_state_e next_state;

    //////////////////////////////
    // State register
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state <= ST_IDLE;
        end else begin
            state <= next_state;
        end
    end

    //////////////////////////////
    // Next state
    always_comb begin
        next_state = state;
        case (state)
            ST_IDLE: begin
                if (enable) begin
                    next_state = ST_LOOKUP;     // Request taken this edge
                end
            end
            ST_LOOKUP: begin
                if (ctrl.hit) begin
                    next_state = ST_IDLE;       // Access done in lookup
                end else if (ctrl.victim_dirty) begin
                    next_state = ST_WRITE_BACK;
                end else begin
                    next_state = ST_REFILL;     // Clean or empty line
                end
            end
            ST_WRITE_BACK: next_state = ST_REFILL;
            ST_REFILL:     next_state = ST_ACCESS;
            ST_ACCESS:     next_state = ST_IDLE;
            default:       next_state = ST_IDLE;
        endcase
    end

    // One strobe per state, accept only while idle
    assign ctrl.accept     = (state == ST_IDLE) && enable;
    assign ctrl.lookup     = (state == ST_LOOKUP);
    assign ctrl.write_back = (state == ST_WRITE_BACK);
    assign ctrl.refill     = (state == ST_REFILL);
    assign ctrl.access     = (state == ST_ACCESS);

    assign busy = (state != ST_IDLE); // Enable ignored while high

endmodule

// ==== logic/l1_line_store.sv ====
//////////////////////////////
// L1 line store
// Request register, direct-mapped arrays, hit compare and byte access
//////////////////////////////
`timescale 1ns/100ps

module l1_line_store (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  rw,
    input  cache_addr_pkg::addr_t address,
    input  cache_addr_pkg::byte_t data_in,
    output cache_addr_pkg::byte_t data_out,
    cache_ctrl_if.store           ctrl,
    mem_bus_if.ctrl               mem
);
    import cache_addr_pkg::*;
    import cache_ctrl_pkg::*;

    //////////////////////////////
    // Captured request
    tag_t    req_tag;
    index_t  req_index;
    offset_t req_offset;
    byte_t   req_data;

    // L1 arrays
    line_t                l1_data [L1_LINES];
    tag_t                 l1_tag  [L1_LINES];
    logic  [L1_LINES-1:0] l1_valid;
    logic  [L1_LINES-1:0] l1_dirty;

    line_t cur_line;   // Line at the request index
    tag_t  cur_tag;    // Its stored tag
    logic  do_access;  // Byte read or merge this cycle

    // Request inputs need not be held after acceptance
    always_ff @(posedge clk) begin
        if (ctrl.accept) begin
            {req_tag, req_index, req_offset} <= address;
            req_data <= data_in;
            ctrl.op  <= cache_op_e'(rw);  // 1 means write
        end
    end

    //////////////////////////////
    // Lookup
    assign cur_line = l1_data[req_index];
    assign cur_tag  = l1_tag[req_index];

    assign ctrl.hit          = l1_valid[req_index] && (cur_tag == req_tag);
    assign ctrl.victim_dirty = l1_valid[req_index] && l1_dirty[req_index];

    // Hit finishes in lookup, a miss waits for the access strobe
    assign do_access = (ctrl.lookup && ctrl.hit) || ctrl.access;

    //////////////////////////////
    // Memory port
    // Victim address comes back from the stored tag
    assign mem.word_addr = ctrl.write_back ? {cur_tag, req_index} : {req_tag, req_index};
    assign mem.wdata     = cur_line;
    assign mem.we        = ctrl.write_back;

    // Line data and tags
    always_ff @(posedge clk) begin
        if (ctrl.refill) begin
            l1_data[req_index] <= mem.rdata;  // Whole line from memory
            l1_tag[req_index]  <= req_tag;
        end else if (do_access && (ctrl.op == OP_WRITE)) begin
            l1_data[req_index][req_offset] <= req_data;  // Merge one byte
        end
    end

    // Valid and dirty flags
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            l1_valid <= '0;
            l1_dirty <= '0;
        end else if (ctrl.refill) begin
            l1_valid[req_index] <= 1'b1;
            l1_dirty[req_index] <= 1'b0;  // Fresh copy matches memory
        end else if (do_access && (ctrl.op == OP_WRITE)) begin
            l1_dirty[req_index] <= 1'b1;
        end
    end

    //////////////////////////////
    // Read data
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            data_out <= '0;
        end else if (do_access && (ctrl.op == OP_READ)) begin
            data_out <= cur_line[req_offset];  // Held through writes
        end
    end

endmodule

// ==== logic/main_memory.sv ====
//////////////////////////////
// Word-addressed main memory
// Combinational read, write on the clock edge
//////////////////////////////
`timescale 1ns/100ps
`include "cache_macros.svh"

module main_memory (
    input logic     clk,
    mem_bus_if.mem  mem
);
    import cache_addr_pkg::*;

    line_t mem_array [`MEM_WORDS];

    // Each word starts out holding its own index
    initial begin
        for (int i = 0; i < `MEM_WORDS; i++) begin
            mem_array[i] = line_t'(i);
        end
    end

    assign mem.rdata = mem_array[mem.word_addr];  // No read latency

    always @(posedge clk) begin
        if (mem.we) begin
            mem_array[mem.word_addr] <= mem.wdata;  // Victim write-back
        end
    end

endmodule

// ==== logic/mem_controller.sv ====
//////////////////////////////
// Memory controller with L1 cache
//////////////////////////////
`timescale 1ns/100ps

module mem_controller (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  enable,
    input  logic                  rw,       // 1 means write
    input  cache_addr_pkg::addr_t address,
    input  cache_addr_pkg::byte_t data_in,
    output cache_addr_pkg::byte_t data_out,
    output logic                  busy
);

    // Internal buses
    cache_ctrl_if ctrl_bus ();  // FSM to store
    mem_bus_if    mem_bus ();   // Store to memory

    //////////////////////////////
    // Sequencing
    cache_ctrl_fsm u_fsm (
        .clk     (clk),
        .reset_n (reset_n),
        .enable  (enable),
        .ctrl    (ctrl_bus.fsm),
        .busy    (busy)
    );

    // L1 arrays and datapath
    l1_line_store u_store (
        .clk      (clk),
        .reset_n  (reset_n),
        .rw       (rw),
        .address  (address),
        .data_in  (data_in),
        .data_out (data_out),
        .ctrl     (ctrl_bus.store),
        .mem      (mem_bus.ctrl)
    );

    // Backing store
    main_memory u_main_memory (
        .clk (clk),
        .mem (mem_bus.mem)
    );

endmodule

// ==== tb/mem_controller_properties.sv ====
//////////////////////////////
// Busy and FSM sequencing properties
//////////////////////////////
`timescale 1ns/100ps

module mem_controller_properties (
    input logic                        clk,
    input logic                        reset_n,
    input logic                        enable,
    input logic                        busy,
    input cache_ctrl_pkg::ctrl_state_e state,
    input logic                        victim_dirty
);
    import cache_ctrl_pkg::*;

    // Idle right out of reset
    assert property (@(posedge clk) $rose(reset_n) |-> !busy)
        else $error("busy high in the cycle after reset release");

    assert property (@(posedge clk) disable iff (!reset_n) (enable && !busy) |=> busy)
        else $error("accepted request did not raise busy");

    // Dirty miss is the longest case at 4 cycles
    assert property (@(posedge clk) disable iff (!reset_n)
        !(busy && $past(busy, 1) && $past(busy, 2) && $past(busy, 3) && $past(busy, 4)))
        else $error("busy stayed high longer than 4 cycles");

    assert property (@(posedge clk) disable iff (!reset_n)
        (state == ST_WRITE_BACK) |-> ($past(state) == ST_LOOKUP) && $past(victim_dirty))
        else $error("write-back entered without a dirty victim");

endmodule

bind mem_controller mem_controller_properties u_properties (
    .clk          (clk),
    .reset_n      (reset_n),
    .enable       (enable),
    .busy         (busy),
    .state        (u_fsm.state),
    .victim_dirty (ctrl_bus.victim_dirty)
);

// ==== tb/mem_controller_tb.sv ====
//////////////////////////////
// Memory controller testbench
// Directed and random traffic against a shadow-memory model
//////////////////////////////
`timescale 1ns/100ps

module mem_controller_tb;
    import cache_addr_pkg::*;

    localparam int RESET_CYCLES    = 5;
    localparam int RANDOM_REQUESTS = 300;
    localparam int NUM_REQUESTS    = 8 + 5 + 4 + RANDOM_REQUESTS; // Directed plus random
    localparam int TIMEOUT_CYCLES  = RESET_CYCLES + 8 * NUM_REQUESTS;

    logic  clk;
    logic  reset_n;
    logic  enable;
    logic  rw;
    addr_t address;
    byte_t data_in;
    byte_t data_out;
    logic  busy;

    byte_t       shadow  [65536];   // Bytes written so far
    bit          written [65536];   // Per-byte written flags
    logic [31:0] lfsr_state = 32'h4374;
    byte_t       last_read = '0;    // data_out holds this through writes
    byte_t       check_expected = '0;
    string       check_name = "none";
    logic        busy_prev = 1'b0;
    int          checks_done = 0;
    int          requests_issued = 0;
    int          cycle_count = 0;
    addr_t       cold_addrs [4] = '{16'h0004, 16'h0101, 16'h2A4B, 16'hFFFE};

    mem_controller u_mem_controller (
        .clk      (clk),
        .reset_n  (reset_n),
        .enable   (enable),
        .rw       (rw),
        .address  (address),
        .data_in  (data_in),
        .data_out (data_out),
        .busy     (busy)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;  // 40 ns period
    end

    //////////////////////////////
    // Helpers
    task automatic stop_with_error(input string line);
        $display("%s", line);
        $display("TB FAILED");
        $fatal(1, "Simulation stopped on first error");
    endtask

    // Galois form with taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        return {1'b0, state[31:1]} ^ (state[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    function automatic byte_t take_bits(input int count);
        byte_t value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[6:0], lfsr_state[0]};  // One step per bit
            lfsr_state = lfsr_step(lfsr_state);
        end
        return value;
    endfunction

    // Written byte, else byte of the word index the memory starts with
    function automatic byte_t expected_byte(input addr_t addr);
        logic [3:0][7:0] word_bytes;
        word_bytes = {18'd0, addr[15:2]};
        if (written[addr]) begin
            return shadow[addr];
        end
        return word_bytes[addr[1:0]];
    endfunction

    // Drive one request, then wait for busy to drop
    task automatic issue_request(input logic write, input addr_t addr, input byte_t data,
                                 input string name);
        @(posedge clk);
        enable  <= 1'b1;
        rw      <= write;
        address <= addr;
        data_in <= data;
        check_name = name;
        if (write) begin
            shadow[addr]  = data;
            written[addr] = 1'b1;
        end else begin
            last_read = expected_byte(addr);
        end
        check_expected = last_read;
        @(posedge clk);             // Acceptance edge
        enable <= 1'b0;
        requests_issued++;
        do @(negedge clk); while (busy);
    endtask

    //////////////////////////////
    // Checker that runs at the fall of busy
    always @(negedge clk) begin
        if (busy_prev && !busy) begin
            assert (data_out == check_expected) else
                stop_with_error($sformatf("ERR %s expected %h actual %h",
                                          check_name, check_expected, data_out));
            checks_done++;
        end
        busy_prev = busy;
    end

    // Cycle budget for the whole run
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            stop_with_error("Timeout, a request never finished within the cycle budget");
        end
    end

    //////////////////////////////
    // Stimulus
    initial begin : stimulus
        byte_t tag_sel;
        byte_t index_sel;
        byte_t offset_sel;
        byte_t op_sel;
        byte_t data_sel;
        addr_t rand_addr;

        reset_n = 1'b0;
        enable  = 1'b0;
        rw      = 1'b0;
        address = '0;
        data_in = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset_n <= 1'b1;
        @(negedge clk);
        assert (busy == 1'b0) else
            stop_with_error($sformatf("ERR reset_busy expected 0 actual %0b", busy));
        assert (data_out == 8'h00) else
            stop_with_error($sformatf("ERR reset_data expected 00 actual %h", data_out));

        // Cold miss, then a hit on the same line
        for (int i = 0; i < 4; i++) begin
            issue_request(1'b0, cold_addrs[i], 8'h00, "cold_read");
            issue_request(1'b0, cold_addrs[i] ^ 16'h0001, 8'h00, "cold_hit");
        end

        issue_request(1'b1, 16'h0842, 8'h3C, "write_hold");
        for (int i = 0; i < 4; i++) begin
            issue_request(1'b0, 16'h0840 + 16'(i), 8'h00, "write_read");
        end

        // Same index and a new tag push the dirty line out
        issue_request(1'b1, {8'h12, 6'd13, 2'd0}, 8'hA5, "evict_write");
        issue_request(1'b0, {8'h56, 6'd13, 2'd1}, 8'h00, "evict_victim");
        issue_request(1'b0, {8'h12, 6'd13, 2'd0}, 8'h00, "evict_reread");
        issue_request(1'b0, {8'h12, 6'd13, 2'd3}, 8'h00, "evict_neighbour");

        // 4 tags by 8 indexes by 4 offsets
        for (int n = 0; n < RANDOM_REQUESTS; n++) begin
            tag_sel    = take_bits(2);
            index_sel  = take_bits(3);
            offset_sel = take_bits(2);
            op_sel     = take_bits(1);
            data_sel   = take_bits(8);
            rand_addr  = {8'h40 | {6'd0, tag_sel[1:0]}, 3'b001, index_sel[2:0], offset_sel[1:0]};
            if (op_sel[0]) begin
                issue_request(1'b1, rand_addr, data_sel, "random_write");
            end else begin
                issue_request(1'b0, rand_addr, data_sel, "random_read");
            end
        end

        @(negedge clk);
        if (checks_done != requests_issued) begin
            stop_with_error($sformatf("Only %0d of %0d requests reached a check",
                                      checks_done, requests_issued));
        end else begin
            $display("TB PASSED");
            $finish;
        end
    end

endmodule

// ==== sim.f ====
+incdir+logic
logic/cache_addr_pkg.sv
logic/cache_ctrl_pkg.sv
logic/cache_ctrl_if.sv
logic/mem_bus_if.sv
logic/cache_ctrl_fsm.sv
logic/l1_line_store.sv
logic/main_memory.sv
logic/mem_controller.sv
tb/mem_controller_properties.sv
tb/mem_controller_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile the memory controller testbench with Verilator and run it.
# Exit status is nonzero when the build or the simulation fails.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f sim.f \
    --top-module mem_controller_tb \
    -o mem_controller_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./obj_dir/mem_controller_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi

exit 0
